/* rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath and register file sizing
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000

// major opcodes of the kept RV32I subset
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`endif

/* rv_pkg.sv */
`default_nettype none
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_op_e;

    // --------------------
    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // --------------------
    // stage payloads
    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      rs1_data;
        word_t      rs2_data;
        reg_addr_t  rd;
        logic       reg_write;
        alu_op_e    alu_op;
        branch_op_e branch_op;
        logic       is_jal;
        logic       is_jalr;
        logic       use_imm;
        logic       use_pc_a;
        logic       zero_a;
        logic       link;
    } dec_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      reg_write;
        logic      link;
        word_t     alu_result;
        word_t     pc_plus4;
    } ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_regfile (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rv_pkg::reg_addr_t i_rs1,
    input  wire rv_pkg::reg_addr_t i_rs2,
    input  wire rv_pkg::wb_t       i_wb,
    output rv_pkg::word_t          o_rs1_data,
    output rv_pkg::word_t          o_rs2_data
);

    rv_pkg::word_t regs [`RV_NREGS];

    // x0 never gets a valid write strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 reads zero and a same-cycle write passes through
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb.valid && i_wb.rd == addr) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rv_decode (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rv_pkg::word_t  i_instr,
    input  wire rv_pkg::redirect_t i_redirect,
    input  wire rv_pkg::wb_t    i_wb,
    output rv_pkg::word_t       o_pc,
    output rv_pkg::dec_t        o_dec
);

    rv_pkg::word_t   r_pc;
    rv_pkg::instr_u  ins;
    rv_pkg::word_t   rs1_data;
    rv_pkg::word_t   rs2_data;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    rv_pkg::alu_op_e arith_op;
    rv_pkg::branch_op_e br_op;
    rv_pkg::dec_t    d_next;
    rv_pkg::dec_t    r_dec;

    // --------------------
    // program counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_pc <= `RV_RESET_PC;
        end else if (i_redirect.taken) begin
            r_pc <= i_redirect.target;
        end else begin
            r_pc <= r_pc + 32'd4;
        end
    end

    assign ins = i_instr;

    // sign-extended immediates per format
    assign imm_i = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
    assign imm_b = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
    assign imm_u = {ins.u.imm_31_12, 12'h000};
    assign imm_j = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11, ins.j.imm_10_1, 1'b0};

    rv_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .i_rs1      (ins.r.rs1),
        .i_rs2      (ins.r.rs2),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // alu op from funct3, funct7 bit 5 picks sub and sra
    always_comb begin
        case (ins.r.funct3)
            3'b000: begin
                if (ins.r.opcode == `RV_OP_REG && ins.r.funct7[5]) begin
                    arith_op = rv_pkg::ALU_SUB;
                end else begin
                    arith_op = rv_pkg::ALU_ADD;
                end
            end
            3'b001: arith_op = rv_pkg::ALU_SLL;
            3'b010: arith_op = rv_pkg::ALU_SLT;
            3'b011: arith_op = rv_pkg::ALU_SLTU;
            3'b100: arith_op = rv_pkg::ALU_XOR;
            3'b101: arith_op = ins.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110: arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (ins.b.funct3)
            3'b000: br_op = rv_pkg::BR_EQ;
            3'b001: br_op = rv_pkg::BR_NE;
            3'b100: br_op = rv_pkg::BR_LT;
            3'b101: br_op = rv_pkg::BR_GE;
            3'b110: br_op = rv_pkg::BR_LTU;
            3'b111: br_op = rv_pkg::BR_GEU;
            default: br_op = rv_pkg::BR_NONE;
        endcase
    end

    // --------------------
    // control fields
    always_comb begin
        d_next           = '0;
        d_next.valid     = 1'b1;
        d_next.pc        = r_pc;
        d_next.rs1       = ins.r.rs1;
        d_next.rs2       = ins.r.rs2;
        d_next.rs1_data  = rs1_data;
        d_next.rs2_data  = rs2_data;
        d_next.rd        = ins.r.rd;
        d_next.alu_op    = rv_pkg::ALU_ADD;
        d_next.branch_op = rv_pkg::BR_NONE;
        case (ins.r.opcode)
            `RV_OP_LUI: begin
                d_next.imm       = imm_u;
                d_next.reg_write = 1'b1;
                d_next.zero_a    = 1'b1;
                d_next.use_imm   = 1'b1;
            end
            `RV_OP_AUIPC: begin
                d_next.imm       = imm_u;
                d_next.reg_write = 1'b1;
                d_next.use_pc_a  = 1'b1;
                d_next.use_imm   = 1'b1;
            end
            `RV_OP_JAL: begin
                d_next.imm       = imm_j;
                d_next.reg_write = 1'b1;
                d_next.is_jal    = 1'b1;
                d_next.link      = 1'b1;
            end
            `RV_OP_JALR: begin
                d_next.imm       = imm_i;
                d_next.reg_write = 1'b1;
                d_next.is_jalr   = 1'b1;
                d_next.link      = 1'b1;
            end
            `RV_OP_BRANCH: begin
                d_next.imm       = imm_b;
                d_next.branch_op = br_op;
            end
            `RV_OP_IMM: begin
                d_next.imm       = imm_i;
                d_next.reg_write = 1'b1;
                d_next.use_imm   = 1'b1;
                d_next.alu_op    = arith_op;
            end
            `RV_OP_REG: begin
                d_next.reg_write = 1'b1;
                d_next.alu_op    = arith_op;
            end
            // unknown opcode, dropped below
            default: d_next.valid = 1'b0;
        endcase
    end

    // decode to execute register, bubble on redirect
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_dec <= '0;
        end else if (i_redirect.taken || !d_next.valid) begin
            r_dec <= '0;
        end else begin
            r_dec <= d_next;
        end
    end

    assign o_pc  = r_pc;
    assign o_dec = r_dec;

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire rv_pkg::dec_t i_dec,
    input  wire rv_pkg::wb_t  i_wb,
    output rv_pkg::redirect_t o_redirect,
    output rv_pkg::ex_t       o_ex
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_y;
    rv_pkg::word_t jalr_sum;
    logic          br_true;

    // --------------------
    // forwarding from write-back
    always_comb begin
        if (i_wb.valid && i_wb.rd == i_dec.rs1) begin
            op_a = i_wb.data;
        end else begin
            op_a = i_dec.rs1_data;
        end
        if (i_wb.valid && i_wb.rd == i_dec.rs2) begin
            op_b = i_wb.data;
        end else begin
            op_b = i_dec.rs2_data;
        end
    end

    // lui zeroes a, auipc uses pc
    always_comb begin
        if (i_dec.zero_a) begin
            alu_a = '0;
        end else if (i_dec.use_pc_a) begin
            alu_a = i_dec.pc;
        end else begin
            alu_a = op_a;
        end
        alu_b = i_dec.use_imm ? i_dec.imm : op_b;
    end

    // --------------------
    // alu
    always_comb begin
        case (i_dec.alu_op)
            rv_pkg::ALU_SUB:  alu_y = alu_a - alu_b;
            rv_pkg::ALU_AND:  alu_y = alu_a & alu_b;
            rv_pkg::ALU_OR:   alu_y = alu_a | alu_b;
            rv_pkg::ALU_XOR:  alu_y = alu_a ^ alu_b;
            rv_pkg::ALU_SLL:  alu_y = alu_a << alu_b[4:0];
            rv_pkg::ALU_SRL:  alu_y = alu_a >> alu_b[4:0];
            rv_pkg::ALU_SRA:  alu_y = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::ALU_SLT:  alu_y = ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
            rv_pkg::ALU_SLTU: alu_y = (alu_a < alu_b) ? 32'd1 : 32'd0;
            default:          alu_y = alu_a + alu_b;
        endcase
    end

    // branch compare on forwarded registers
    always_comb begin
        case (i_dec.branch_op)
            rv_pkg::BR_EQ:  br_true = (op_a == op_b);
            rv_pkg::BR_NE:  br_true = (op_a != op_b);
            rv_pkg::BR_LT:  br_true = ($signed(op_a) < $signed(op_b));
            rv_pkg::BR_GE:  br_true = ($signed(op_a) >= $signed(op_b));
            rv_pkg::BR_LTU: br_true = (op_a < op_b);
            rv_pkg::BR_GEU: br_true = (op_a >= op_b);
            default:        br_true = 1'b0;
        endcase
    end

    assign jalr_sum = op_a + i_dec.imm;

    // --------------------
    // redirect and result payload
    always_comb begin
        o_redirect.taken = i_dec.valid && (i_dec.is_jal || i_dec.is_jalr || br_true);
        if (i_dec.is_jalr) begin
            o_redirect.target = {jalr_sum[31:1], 1'b0};
        end else begin
            o_redirect.target = i_dec.pc + i_dec.imm;
        end
    end

    always_comb begin
        o_ex.valid      = i_dec.valid;
        o_ex.rd         = i_dec.rd;
        o_ex.reg_write  = i_dec.reg_write;
        o_ex.link       = i_dec.link;
        o_ex.alu_result = alu_y;
        o_ex.pc_plus4   = i_dec.pc + 32'd4;
    end

endmodule

`default_nettype wire

/* rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  wire              clk,
    input  wire              rst,
    input  wire rv_pkg::ex_t i_ex,
    output rv_pkg::wb_t      o_wb
);

    rv_pkg::ex_t r_ex;

    // execute to result register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_ex <= '0;
        end else begin
            r_ex <= i_ex;
        end
    end

    // --------------------
    // write-back select
    always_comb begin
        o_wb.valid = r_ex.valid && r_ex.reg_write && (r_ex.rd != '0);
        o_wb.rd    = r_ex.rd;
        // jumps write the return address
        if (r_ex.link) begin
            o_wb.data = r_ex.pc_plus4;
        end else begin
            o_wb.data = r_ex.alu_result;
        end
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                clk,
    input  wire                rst,
    input  wire rv_pkg::word_t i_instr,
    output rv_pkg::word_t      o_pc,
    output rv_pkg::wb_t        o_wb
);

    rv_pkg::dec_t      dec;
    rv_pkg::redirect_t redirect;
    rv_pkg::ex_t       ex;
    rv_pkg::wb_t       wb;

    // --------------------
    // fetch and decode
    rv_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .i_instr    (i_instr),
        .i_redirect (redirect),
        .i_wb       (wb),
        .o_pc       (o_pc),
        .o_dec      (dec)
    );

    // alu, branches, jump targets
    rv_execute u_execute (
        .i_dec      (dec),
        .i_wb       (wb),
        .o_redirect (redirect),
        .o_ex       (ex)
    );

    // write-back
    rv_result u_result (
        .clk  (clk),
        .rst  (rst),
        .i_ex (ex),
        .o_wb (wb)
    );

    assign o_wb = wb;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // release shortly after a rising edge, clear of both edges
    initial begin
        o_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2 o_rst = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

    // addi x0, x0, 0 fills the space beyond the program
    localparam rv_pkg::word_t NOP = 32'h0000_0013;
    localparam int MAX_WORDS   = 256;
    localparam int IDLE_CYCLES = 20;

    // characters that open a line of the data file
    localparam int CH_NL   = 10;
    localparam int CH_SP   = 32;
    localparam int CH_HASH = 35;
    localparam int CH_E    = 69;
    localparam int CH_I    = 73;
    localparam int CH_W    = 87;

    logic          clk;
    logic          rst;
    rv_pkg::word_t instr;
    rv_pkg::word_t pc;
    rv_pkg::wb_t   wb;

    rv_pkg::word_t prog [MAX_WORDS];
    int            prog_len;
    rv_pkg::wb_t   exp_q [$];
    rv_pkg::word_t loop_addr;
    logic          have_loop;

    tb_clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv_core UUT (
        .clk     (clk),
        .rst     (rst),
        .i_instr (instr),
        .o_pc    (pc),
        .o_wb    (wb)
    );

    // --------------------
    // error exit and compares
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_wb(input string name, input rv_pkg::wb_t got,
                            input rv_pkg::wb_t want);
        if (got !== want) begin
            abort_run($sformatf(
                "MISMATCH at %0t: %s got valid=%0b rd=x%0d data=%08h, want valid=%0b rd=x%0d data=%08h",
                $time, name, got.valid, got.rd, got.data, want.valid, want.rd, want.data));
        end
    endtask

    task automatic check_pc(input string name, input rv_pkg::word_t got,
                            input rv_pkg::word_t want) ;
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %08h, want %08h",
                                $time, name, got, want));
        end
    endtask

    // program memory, one word per address step of 4
    function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len) begin
            return prog[idx[7:0]];
        end
        return NOP;
    endfunction

    // --------------------
    // data file reader
    task automatic load_input();
        int            fd;
        int            c;
        int            code;
        int            rd_num;
        rv_pkg::word_t val;
        rv_pkg::wb_t   entry;
        prog_len  = 0;
        have_loop = 1'b0;
        fd = $fopen("core_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open core_input.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == CH_HASH) begin
                // skip the rest of a comment line
                while (c != -1 && c != CH_NL) begin
                    c = $fgetc(fd);
                end
            end else if (c == CH_I) begin
                code = $fscanf(fd, " %h", val);
                if (code != 1 || prog_len >= MAX_WORDS) begin
                    abort_run("bad or surplus program line in core_input.txt");
                end
                prog[prog_len[7:0]] = val;
                prog_len++;
            end else if (c == CH_W) begin
                code = $fscanf(fd, " %d %h", rd_num, val);
                if (code != 2 || rd_num < 1 || rd_num > 31) begin
                    abort_run("bad write-back line in core_input.txt");
                end
                entry.valid = 1'b1;
                entry.rd    = rd_num[4:0];
                entry.data  = val;
                exp_q.push_back(entry);
            end else if (c == CH_E) begin
                code = $fscanf(fd, " %h", val);
                if (code != 1) begin
                    abort_run("bad loop address line in core_input.txt");
                end
                loop_addr = val;
                have_loop = 1'b1;
            end else if (c > CH_SP) begin
                abort_run("unknown line tag in core_input.txt");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (!have_loop || prog_len == 0) begin
            abort_run("core_input.txt lacks program words or the loop address");
        end
    endtask

    // --------------------
    // drive fetch data and follow the write-backs
    initial begin
        int          limit;
        int          cycles;
        int          idle;
        int          seen;
        int          total;
        logic        settled;
        rv_pkg::wb_t want;
        instr = NOP;
        load_input();
        total   = exp_q.size();
        limit   = 4 * prog_len + 4 * total + 20;
        cycles  = 0;
        idle    = 0;
        seen    = 0;
        settled = 1'b0;
        while (idle < IDLE_CYCLES) begin
            @(negedge clk);
            instr = fetch_word(pc);
            if (!rst) begin
                check_pc("o_pc", pc, `RV_RESET_PC);
                check_wb("o_wb", wb, '0);
            end else begin
                cycles++;
                if (cycles > limit && seen < total) begin
                    abort_run($sformatf(
                        "timeout after %0d cycles: write-backs stopped arriving, %0d of %0d seen",
                        cycles, seen, total));
                end else if (cycles > limit) begin
                    abort_run("timeout: o_pc never reached the loop address");
                end
                // first cycle out of reset still fetches the reset address
                if (cycles == 1) begin
                    check_pc("o_pc", pc, `RV_RESET_PC);
                end
                if (wb.valid && exp_q.size() == 0) begin
                    abort_run($sformatf("unexpected write-back to x%0d at %0t after the last one",
                                        wb.rd, $time));
                end else if (wb.valid) begin
                    want = exp_q.pop_front();
                    check_wb("o_wb", wb, want);
                    seen++;
                end
                if (exp_q.size() == 0 && pc == loop_addr) begin
                    settled = 1'b1;
                end
                if (settled) begin
                    // the loop jump flushes the word after it, so pc alternates
                    if (pc != loop_addr) begin
                        check_pc("o_pc", pc, loop_addr + 32'd4);
                    end
                    idle++;
                end
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* core_input.txt */
# I <word>: program word, from address 0 up; W <rd> <data>: write-back, in commit order
# E <addr>: address of the closing self-loop
I 00500093
I FFD00113
I 002081B3
I 40208233
I 001122B3
I 00113333
I 005093B3
I 40115413
I 01C15493
I 0FF0C513
I 00708013
I 123455B7
I 00208463
I 00001617
I 00209463
I 06300693
I 00C0076F
I 06200693
I 06100693
I 0301E793
I 01470867
I 06000693
I 00F878B3
I 00114463
I 05F00693
I 00116463
I 0020D463
I 05E00693
I 00117463
I 05D00693
I 0000006F
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 00000008
W 5 00000001
W 6 00000000
W 7 0000000A
W 8 FFFFFFFE
W 9 0000000F
W 10 000000FA
W 11 12345000
W 12 00001034
W 14 00000044
W 15 00000032
W 16 00000054
W 17 00000010
E 00000078

/* rv_core.f */
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vtb_rv_core: rv_core.f rv_config.svh rv_pkg.sv rv_regfile.sv rv_decode.sv \
		rv_execute.sv rv_result.sv rv_core.sv tb_clock_gen.sv tb_rv_core.sv
	verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o Vtb_rv_core

run: obj_dir/Vtb_rv_core core_input.txt
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
